//--- hw/out_fm_pkg.sv
/* Widths and packed element types shared across the output feature map store path.
   Modules reference these by scoped name. */
package out_fm_pkg;

    parameter int cw = 16; // Coordinate width
    parameter int dw = 32; // Data word width
    parameter int aw = 24; // Memory word address width

    typedef logic [cw-1:0] coord_t;
    typedef logic [aw-1:0] addr_t;

    // Tile origin in the full output feature map, held for a whole tile
    typedef struct packed {
        coord_t n;
        coord_t row;
        coord_t col;
    } tile_base_t;

    // One legal output element with absolute coordinates
    typedef struct packed {
        logic [dw-1:0] data;
        coord_t        n;
        coord_t        row;
        coord_t        col;
    } out_elem_t;

    // Single word write toward memory
    typedef struct packed {
        addr_t         addr;
        logic [dw-1:0] data;
    } mem_wr_t;

endpackage

//--- hw/nest3_counter.sv
/* Three-level nested index counter for walking a tile in column, row, channel order.
   Advances once per enable and pulses done on the last index of the tile. */
module nest3_counter #(
    parameter int n0_max = 4, // Innermost range, columns
    parameter int n1_max = 4, // Rows
    parameter int n2_max = 2  // Outermost range, channels
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ena,
    output out_fm_pkg::coord_t cnt0,
    output out_fm_pkg::coord_t cnt1,
    output out_fm_pkg::coord_t cnt2,
    output logic               done
);

    logic last0;
    logic last1;
    logic last2;

    assign last0 = (cnt0 == out_fm_pkg::coord_t'(n0_max - 1));
    assign last1 = (cnt1 == out_fm_pkg::coord_t'(n1_max - 1));
    assign last2 = (cnt2 == out_fm_pkg::coord_t'(n2_max - 1));

    // High together with the enable of the final element
    assign done = ena && last0 && last1 && last2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (ena) begin
            cnt0 <= last0 ? '0 : cnt0 + 1'b1;
            if (last0) begin // Column wrap carries into row
                cnt1 <= last1 ? '0 : cnt1 + 1'b1;
                if (last1) begin
                    cnt2 <= last2 ? '0 : cnt2 + 1'b1;
                end
            end
        end
    end

    // Indices must stay strictly inside their ranges across every wrap
    idx_in_range: assert property (@(posedge clk) disable iff (rst)
        (cnt0 < out_fm_pkg::coord_t'(n0_max)) &&
        (cnt1 < out_fm_pkg::coord_t'(n1_max)) &&
        (cnt2 < out_fm_pkg::coord_t'(n2_max)));

endmodule

//--- hw/out_fm_st_filter.sv
/* Tags each streamed tile element with absolute coordinates and drops the illegal ones.
   One cycle from in_push to push; tile_done lines up with the last element. */
module out_fm_st_filter #(
    parameter int N  = 5,
    parameter int R  = 10,
    parameter int C  = 9,
    parameter int Tn = 2,
    parameter int Tr = 4,
    parameter int Tc = 4,
    parameter int S  = 1,
    parameter int K  = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_push,
    input  logic [out_fm_pkg::dw-1:0] in_data,
    input  out_fm_pkg::tile_base_t tile_base,
    output logic                   push,
    output out_fm_pkg::out_elem_t  elem,
    output logic                   tile_done
);

    // Valid output steps once the kernel overhang is removed
    localparam int row_step = ((Tr + S - K) / S) * S;
    localparam int col_step = ((Tc + S - K) / S) * S;
    localparam int r_step   = ((R + S - K) / S) * S;

    out_fm_pkg::coord_t tc;
    out_fm_pkg::coord_t tr;
    out_fm_pkg::coord_t tn;
    out_fm_pkg::coord_t tc_q;
    out_fm_pkg::coord_t tr_q;
    out_fm_pkg::coord_t tn_q;
    logic [out_fm_pkg::dw-1:0] data_q;
    logic push_q;
    logic cnt_done;
    logic legal;

    nest3_counter #(
        .n0_max (Tc),
        .n1_max (Tr),
        .n2_max (Tn)
    ) u_cnt (
        .clk  (clk),
        .rst  (rst),
        .ena  (in_push),
        .cnt0 (tc),
        .cnt1 (tr),
        .cnt2 (tn),
        .done (cnt_done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push_q    <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            push_q    <= in_push;
            tile_done <= cnt_done; // Delayed to match the element stage
        end
    end

    // Indices sampled before the counter steps past them
    always_ff @(posedge clk) begin
        if (in_push) begin
            data_q <= in_data;
            tc_q   <= tc;
            tr_q   <= tr;
            tn_q   <= tn;
        end
    end

    always_comb begin
        elem.data = data_q;
        elem.n    = tile_base.n + tn_q;
        elem.row  = tile_base.row + tr_q;
        elem.col  = tile_base.col + tc_q;
    end

    assign legal = (elem.n < out_fm_pkg::coord_t'(N)) &&
                   (elem.row < out_fm_pkg::coord_t'(r_step)) &&
                   (elem.col < out_fm_pkg::coord_t'(C)) &&
                   (tc_q < out_fm_pkg::coord_t'(col_step)) && // Overlap with next tile
                   (tr_q < out_fm_pkg::coord_t'(row_step));

    assign push = push_q && legal;

endmodule

//--- hw/out_fm_fifo.sv
/* Synchronous FIFO of tagged output elements between the filter and the writer.
   Head is registered on pop; a push while full is dropped and flagged. */
module out_fm_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  out_fm_pkg::out_elem_t din,
    input  logic                  pop,
    output out_fm_pkg::out_elem_t head,
    output logic                  empty,
    output logic                  overflow
);

    localparam int pw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

    out_fm_pkg::out_elem_t mem [fifo_depth];

    logic [pw-1:0] wr_ptr;
    logic [pw-1:0] rd_ptr;
    logic [pw:0]   count; // Occupancy, 0 to fifo_depth
    logic          full;
    logic          do_push;
    logic          do_pop;

    function automatic logic [pw-1:0] ptr_inc(input logic [pw-1:0] p);
        return (p == pw'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == (pw + 1)'(fifo_depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            head <= mem[rd_ptr];
        end
    end

    // Writer must only pop what is there
    no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

    // Filter stream rate must never outrun the drain
    no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

//--- hw/out_fm_wr_ctrl.sv
/* Drains the element FIFO into linear memory writes.
   Pop, head register and write stage form a pipeline; mem_busy holds back new pops. */
module out_fm_wr_ctrl #(
    parameter int N = 5,
    parameter int R = 10,
    parameter int C = 9
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  empty,
    input  out_fm_pkg::out_elem_t head,
    input  logic                  mem_busy,
    output logic                  pop,
    output logic                  mem_wr_en,
    output out_fm_pkg::mem_wr_t   mem_wr
);

    logic        head_vld;  // FIFO head holds a freshly popped element
    logic [31:0] addr_full; // Unwrapped address before narrowing

    // Memory stall only stops new pops, in-flight elements drain
    assign pop = !empty && !mem_busy;

    assign addr_full = (32'(head.n) * 32'(R) + 32'(head.row)) * 32'(C) + 32'(head.col);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_vld  <= 1'b0;
            mem_wr_en <= 1'b0;
        end else begin
            head_vld  <= pop;
            mem_wr_en <= head_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (head_vld) begin
            mem_wr.addr <= out_fm_pkg::addr_t'(addr_full);
            mem_wr.data <= head.data;
        end
    end

    // Coordinates passed by the filter must land inside the output map
    addr_in_map: assert property (@(posedge clk) disable iff (rst)
        head_vld |-> (addr_full < 32'(N * R * C)));

endmodule

//--- hw/out_fm_store.sv
/* Top of the output feature map store path: filter, element FIFO and memory writer.
   Map, tile and kernel dimensions are set here and handed down. */
module out_fm_store #(
    parameter int N          = 5,
    parameter int R          = 10,
    parameter int C          = 9,
    parameter int Tn         = 2,
    parameter int Tr         = 4,
    parameter int Tc         = 4,
    parameter int S          = 1,
    parameter int K          = 3,
    parameter int fifo_depth = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_push,
    input  logic [out_fm_pkg::dw-1:0] in_data,
    input  out_fm_pkg::tile_base_t    tile_base,
    input  logic                      mem_busy,
    output logic                      mem_wr_en,
    output out_fm_pkg::mem_wr_t       mem_wr,
    output logic                      tile_done,
    output logic                      overflow
);

    logic                  push;
    out_fm_pkg::out_elem_t elem;
    logic                  pop;
    logic                  empty;
    out_fm_pkg::out_elem_t head;

    out_fm_st_filter #(
        .N  (N),
        .R  (R),
        .C  (C),
        .Tn (Tn),
        .Tr (Tr),
        .Tc (Tc),
        .S  (S),
        .K  (K)
    ) u_filter (
        .clk       (clk),
        .rst       (rst),
        .in_push   (in_push),
        .in_data   (in_data),
        .tile_base (tile_base),
        .push      (push),
        .elem      (elem),
        .tile_done (tile_done)
    );

    out_fm_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .din      (elem),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .overflow (overflow)
    );

    out_fm_wr_ctrl #(
        .N (N),
        .R (R),
        .C (C)
    ) u_wr_ctrl (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .head      (head),
        .mem_busy  (mem_busy),
        .pop       (pop),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr)
    );

endmodule

//--- dv/tb_out_fm_store.sv
/* Directed testbench for the output feature map store path.
   Streams whole tiles, models legality and addressing, and checks every memory write. */
module tb_out_fm_store;

    localparam int N = 5;
    localparam int R = 10;
    localparam int C = 9;
    localparam int Tn = 2;
    localparam int Tr = 4;
    localparam int Tc = 4;
    localparam int S = 1;
    localparam int K = 3;
    localparam int fifo_depth = 8;
    localparam int clk_period = 40;
    localparam int tile_len = Tn * Tr * Tc;
    localparam int total_pushes = 6 * tile_len; // Six tiles over all tests

    // Legal window derived from kernel and stride
    localparam int row_step = ((Tr + S - K) / S) * S;
    localparam int col_step = ((Tc + S - K) / S) * S;
    localparam int r_step = ((R + S - K) / S) * S;

    logic clk;
    logic rst;
    logic in_push;
    logic [out_fm_pkg::dw-1:0] in_data;
    out_fm_pkg::tile_base_t tile_base;
    logic mem_busy;
    logic mem_wr_en;
    out_fm_pkg::mem_wr_t mem_wr;
    logic tile_done;
    logic overflow;

    out_fm_pkg::mem_wr_t exp_q[$]; // Expected writes in stream order
    integer seed = 68186;
    logic done_due = 1'b0;
    bit busy_en = 1'b0;
    int busy_left = 0;
    int writes_seen = 0;
    int dones_seen = 0;
    logic busy_q1 = 1'b0; // mem_busy at the last rising edge
    logic busy_q2 = 1'b0; // One edge earlier, the pop cycle of a write now visible

    out_fm_store #(
        .N          (N),
        .R          (R),
        .C          (C),
        .Tn         (Tn),
        .Tr         (Tr),
        .Tc         (Tc),
        .S          (S),
        .K          (K),
        .fifo_depth (fifo_depth)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .in_push   (in_push),
        .in_data   (in_data),
        .tile_base (tile_base),
        .mem_busy  (mem_busy),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr),
        .tile_done (tile_done),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_wr(input out_fm_pkg::mem_wr_t got, input out_fm_pkg::mem_wr_t exp);
        if (got.addr !== exp.addr) begin
            abort_run($sformatf("ERR mem_wr.addr got %h exp %h", got.addr, exp.addr));
        end
        if (got.data !== exp.data) begin
            abort_run($sformatf("ERR mem_wr.data got %h exp %h", got.data, exp.data));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("%s: saw %0d, expected %0d", what, got, exp));
        end
    endtask

    function automatic out_fm_pkg::tile_base_t make_base(input int n, input int row,
                                                         input int col);
        out_fm_pkg::tile_base_t b;
        b.n = out_fm_pkg::coord_t'(n);
        b.row = out_fm_pkg::coord_t'(row);
        b.col = out_fm_pkg::coord_t'(col);
        return b;
    endfunction

    // Reference legality check on tile indices and absolute coordinates
    function automatic bit elem_legal(input out_fm_pkg::tile_base_t b, input int tn, input int tr,
                                      input int tc);
        int n_abs;
        int row_abs;
        int col_abs;
        n_abs = int'(b.n) + tn;
        row_abs = int'(b.row) + tr;
        col_abs = int'(b.col) + tc;
        return (n_abs < N) && (row_abs < r_step) && (col_abs < C) &&
               (tc < col_step) && (tr < row_step);
    endfunction

    // Flags of the last rising edge are checked before new inputs go out
    task automatic drive_cycle(input logic push_i, input logic [31:0] data_i,
                               input logic last_i);
        @(negedge clk);
        compare_bit("tile_done", tile_done, done_due);
        compare_bit("overflow", overflow, 1'b0);
        done_due = push_i && last_i;
        in_push = push_i;
        in_data = data_i;
        if (busy_en && busy_left == 0 && !mem_busy && ($random(seed) & 3) == 0) begin
            busy_left = 1 + (($random(seed) & 32'h7fff_ffff) % 6); // Stall run of 1 to 6
        end
        mem_busy = (busy_left > 0);
        if (busy_left > 0) begin
            busy_left = busy_left - 1;
        end
    endtask

    task automatic run_tile(input out_fm_pkg::tile_base_t b, input int max_gap);
        int tn;
        int tr;
        int tc;
        int gap;
        logic [31:0] data;
        out_fm_pkg::mem_wr_t exp;
        tile_base = b; // Previous tile has already left the filter stage
        for (int idx = 0; idx < tile_len; idx++) begin
            tc = idx % Tc;
            tr = (idx / Tc) % Tr;
            tn = idx / (Tc * Tr);
            gap = (max_gap > 0) ? (($random(seed) & 32'h7fff_ffff) % (max_gap + 1)) : 0;
            repeat (gap) drive_cycle(1'b0, '0, 1'b0);
            data = $random(seed);
            drive_cycle(1'b1, data, idx == tile_len - 1);
            if (elem_legal(b, tn, tr, tc)) begin
                exp.addr = out_fm_pkg::addr_t'(((int'(b.n) + tn) * R + int'(b.row) + tr) * C +
                                               int'(b.col) + tc);
                exp.data = data;
                exp_q.push_back(exp);
            end
        end
        drive_cycle(1'b0, '0, 1'b0); // Sees tile_done
        drive_cycle(1'b0, '0, 1'b0);
    endtask

    task automatic drain_writes();
        busy_en = 1'b0;
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, '0, 1'b0);
        end
        repeat (4) drive_cycle(1'b0, '0, 1'b0); // Room for a stray write to show up
    endtask

    task automatic interior_tile();
        int start;
        start = writes_seen;
        run_tile(make_base(0, 0, 0), 0);
        drain_writes();
        check_count("interior tile writes", writes_seen - start, 8);
    endtask

    task automatic row_col_edge_tile();
        int start;
        start = writes_seen;
        run_tile(make_base(0, 7, 8), 0);
        drain_writes();
        check_count("row and column edge tile writes", writes_seen - start, 2);
    endtask

    task automatic channel_edge_tile();
        int start;
        start = writes_seen;
        run_tile(make_base(4, 0, 0), 0);
        drain_writes();
        check_count("channel edge tile writes", writes_seen - start, 4);
    endtask

    task automatic stalled_memory();
        int start;
        start = writes_seen;
        busy_en = 1'b1;
        run_tile(make_base(1, 2, 3), 0);
        drain_writes();
        check_count("writes under memory stalls", writes_seen - start, 8);
    endtask

    task automatic gapped_two_tiles();
        int start;
        int done_start;
        start = writes_seen;
        done_start = dones_seen;
        run_tile(make_base(0, 0, 0), 3);
        run_tile(make_base(2, 4, 5), 3);
        drain_writes();
        check_count("writes over two gapped tiles", writes_seen - start, 16);
        check_count("tile_done pulses over two tiles", dones_seen - done_start, 2);
    endtask

    // Pop happens two edges before its write shows up
    always @(posedge clk) begin
        busy_q1 <= mem_busy;
        busy_q2 <= busy_q1;
    end

    // Write monitor sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && mem_wr_en && busy_q2) begin
            abort_run("Memory write came from a pop issued while mem_busy was high");
        end
        if (!rst && mem_wr_en) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected memory write to address %h", mem_wr.addr));
            end else begin
                compare_wr(mem_wr, exp_q.pop_front());
                writes_seen = writes_seen + 1;
            end
        end
        if (!rst && tile_done) begin
            dones_seen = dones_seen + 1;
        end
    end

    initial begin
        #(total_pushes * 10 * clk_period);
        abort_run("Timeout: the tests did not complete within the simulation time limit");
    end

    initial begin
        rst = 1'b1;
        in_push = 1'b0;
        in_data = '0;
        tile_base = '0;
        mem_busy = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        interior_tile();
        row_col_edge_tile();
        channel_edge_tile();
        stalled_memory();
        gapped_two_tiles();
        if (exp_q.size() == 0 && writes_seen == 38) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("Write total wrong: %0d seen, %0d still expected",
                                writes_seen, exp_q.size()));
        end
    end

endmodule

//--- verilog.f
hw/out_fm_pkg.sv
hw/nest3_counter.sv
hw/out_fm_st_filter.sv
hw/out_fm_fifo.sv
hw/out_fm_wr_ctrl.sv
hw/out_fm_store.sv
dv/tb_out_fm_store.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the store path testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_out_fm_store -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Test passed$" &&
echo "SIMULATION PASS" || {
    echo "SIMULATION FAIL"
    exit 1
}
